//--- common/fpuPkg.sv
package fpuPkg;

    // operation codes seen on the op port
    typedef enum logic [1:0] {
        opAdd = 2'd0,
        opSub = 2'd1,
        opMul = 2'd2
    } fpuOpT;

    // control unit states visited once per request
    typedef enum logic [2:0] {
        stIdle,
        stCompare,
        stAlign,
        stCompute,
        stMulWait,   // iterative multiply in progress
        stNormalize,
        stAck
    } ctrlStateT;

    localparam int GuardBits = 3; // extra low bits kept during alignment

endpackage

//--- fpu/fpuControl.sv
module fpuControl
    import fpuPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  req,
    input  fpuOpT op,
    input  logic  signA,
    input  logic  signB,
    input  logic  aLarger,
    input  logic  aluDone,
    output logic  ack,
    output logic  cmpLoad,
    output logic  alignLoad,
    output logic  aluStart,
    output logic  isMul,
    output logic  effSub,
    output logic  normLoad,
    output logic  resultSign
);

    ctrlStateT state;
    ctrlStateT nextState;
    logic      isSub;

    assign isMul = (op == opMul);
    assign isSub = (op == opSub);

    // subtracting b is adding b with its sign flipped
    assign effSub = signA ^ signB ^ isSub;

    assign resultSign = isMul   ? (signA ^ signB) :
                        aLarger ? signA : (signB ^ isSub); // larger magnitude wins

    // one strobe per datapath step
    assign cmpLoad   = (state == stCompare);
    assign alignLoad = (state == stAlign);
    assign aluStart  = (state == stCompute);
    assign normLoad  = (state == stNormalize);

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (req && !ack) begin // previous ack must be gone first
                    nextState = stCompare;
                end
            end
            stCompare:   nextState = stAlign;
            stAlign:     nextState = stCompute;
            stCompute:   nextState = isMul ? stMulWait : stNormalize;
            stMulWait: begin
                if (aluDone) begin
                    nextState = stNormalize;
                end
            end
            stNormalize: nextState = stAck;
            stAck: begin
                if (!req) begin   // hold until the requester lets go
                    nextState = stIdle;
                end
            end
            default:     nextState = stIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stIdle;
            ack   <= 1'b0;
        end else begin
            state <= nextState;
            ack   <= (state == stAck); // ack trails the state by one cycle
        end
    end

endmodule

//--- fpu/exponentAlu.sv
module exponentAlu #(
    parameter int ExpWidth  = 8,
    parameter int FracWidth = 23
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cmpLoad,
    input  logic                       isMul,
    input  logic [ExpWidth-1:0]        expA,
    input  logic [ExpWidth-1:0]        expB,
    input  logic [FracWidth-1:0]       fracA,
    input  logic [FracWidth-1:0]       fracB,
    output logic                       aLarger,
    output logic [ExpWidth-1:0]        expDiff,
    output logic signed [ExpWidth+1:0] expWork
);

    localparam logic signed [ExpWidth+1:0] Bias    = (1 << (ExpWidth - 1)) - 1;
    localparam logic signed [ExpWidth+1:0] ZeroExp = {1'b1, {(ExpWidth + 1){1'b0}}};

    logic                       aGe;
    logic                       zeroIn;
    logic signed [ExpWidth+1:0] expSum;

    assign aGe    = ({expA, fracA} >= {expB, fracB}); // magnitude compare on the raw fields
    assign zeroIn = (expA == '0) || (expB == '0);
    assign expSum = $signed({2'b00, expA}) + $signed({2'b00, expB}) - Bias;

    always_ff @(posedge clk) begin
        if (reset) begin
            aLarger <= 1'b0;
            expDiff <= '0;
            expWork <= '0;
        end else if (cmpLoad) begin
            aLarger <= aGe;
            if (isMul) begin
                expDiff <= '0;                        // multiply wants unshifted significands
                expWork <= zeroIn ? ZeroExp : expSum; // a zero factor forces underflow
            end else begin
                expDiff <= aGe ? (expA - expB) : (expB - expA);
                expWork <= aGe ? $signed({2'b00, expA}) : $signed({2'b00, expB});
            end
        end
    end

endmodule

//--- fpu/alignShifter.sv
module alignShifter
    import fpuPkg::*;
#(
    parameter int ExpWidth  = 8,
    parameter int FracWidth = 23
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          alignLoad,
    input  logic                          aLarger,
    input  logic [ExpWidth-1:0]           expDiff,
    input  logic [ExpWidth-1:0]           expA,
    input  logic [ExpWidth-1:0]           expB,
    input  logic [FracWidth-1:0]          fracA,
    input  logic [FracWidth-1:0]          fracB,
    output logic [FracWidth+GuardBits:0]  bigSig,
    output logic [FracWidth+GuardBits:0]  smallSig
);

    localparam int SigWidth = FracWidth + 1 + GuardBits;

    logic [SigWidth-1:0] sigA;
    logic [SigWidth-1:0] sigB;
    logic [SigWidth-1:0] bigNext;
    logic [SigWidth-1:0] smallPre;
    logic [SigWidth-1:0] smallNext;

    // hidden one only for a nonzero exponent
    assign sigA = {(expA != '0), fracA, {GuardBits{1'b0}}};
    assign sigB = {(expB != '0), fracB, {GuardBits{1'b0}}};

    assign bigNext  = aLarger ? sigA : sigB;
    assign smallPre = aLarger ? sigB : sigA;

    // bits below the guard bits are simply lost
    assign smallNext = (expDiff >= SigWidth) ? '0 : (smallPre >> expDiff);

    always_ff @(posedge clk) begin
        if (reset) begin
            bigSig   <= '0;
            smallSig <= '0;
        end else if (alignLoad) begin
            bigSig   <= bigNext;
            smallSig <= smallNext;
        end
    end

endmodule

//--- fpu/mantissaAlu.sv
module mantissaAlu
    import fpuPkg::*;
#(
    parameter int FracWidth = 23
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           aluStart,
    input  logic                           isMul,
    input  logic                           effSub,
    input  logic [FracWidth+GuardBits:0]   bigSig,
    input  logic [FracWidth+GuardBits:0]   smallSig,
    output logic [FracWidth+GuardBits+1:0] aluResult,
    output logic                           aluDone
);

    localparam int SigWidth = FracWidth + 1 + GuardBits;
    localparam int MulWidth = FracWidth + 1;
    localparam int CntWidth = $clog2(MulWidth + 1);

    logic [MulWidth-1:0]   mcand;
    logic [2*MulWidth-1:0] prod;     // upper half accumulates, lower half holds the multiplier
    logic [2*MulWidth-1:0] prodNext;
    logic [MulWidth:0]     partial;
    logic [CntWidth-1:0]   count;
    logic                  busy;

    assign partial  = {1'b0, prod[2*MulWidth-1:MulWidth]} + (prod[0] ? {1'b0, mcand} : '0);
    assign prodNext = {partial, prod[MulWidth-1:1]}; // add then shift right one bit

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            count   <= '0;
            aluDone <= 1'b0;
        end else begin
            aluDone <= 1'b0;
            if (aluStart) begin
                busy    <= isMul;
                count   <= CntWidth'(MulWidth);
                aluDone <= !isMul; // add and subtract finish right away
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == 'd1) begin
                    busy    <= 1'b0;
                    aluDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aluStart) begin
            mcand <= bigSig[SigWidth-1:GuardBits];
            prod  <= {{MulWidth{1'b0}}, smallSig[SigWidth-1:GuardBits]};
            if (!isMul) begin
                aluResult <= effSub ? ({1'b0, bigSig} - {1'b0, smallSig}) :
                                      ({1'b0, bigSig} + {1'b0, smallSig});
            end
        end else if (busy) begin
            prod <= prodNext;
            if (count == 'd1) begin
                // top product bits line up with the carry bit of a sum
                aluResult <= prodNext[2*MulWidth-1 -: SigWidth+1];
            end
        end
    end

endmodule

//--- fpu/normalizer.sv
module normalizer
    import fpuPkg::*;
#(
    parameter int ExpWidth  = 8,
    parameter int FracWidth = 23
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           normLoad,
    input  logic [FracWidth+GuardBits+1:0] aluResult,
    input  logic signed [ExpWidth+1:0]     expWork,
    input  logic                           resultSign,
    output logic [ExpWidth+FracWidth:0]    result
);

    localparam int SigWidth = FracWidth + 1 + GuardBits;
    localparam int LzcWidth = $clog2(SigWidth);
    localparam int EwWidth  = ExpWidth + 2;
    localparam logic signed [EwWidth-1:0] MaxExp = (1 << ExpWidth) - 1;

    logic [LzcWidth-1:0]        lzc;
    logic signed [EwWidth-1:0]  lzcExt;
    logic [SigWidth:0]          shifted;
    logic signed [EwWidth-1:0]  adjExp;
    logic                       carry;
    logic                       sigZero;
    logic [ExpWidth+FracWidth:0] packWord;

    // highest set bit wins, zero input leaves lzc at 0
    always_comb begin
        lzc = '0;
        for (int i = 0; i < SigWidth; i++) begin
            if (aluResult[i]) begin
                lzc = LzcWidth'(SigWidth - 1 - i);
            end
        end
    end

    assign carry   = aluResult[SigWidth];
    assign sigZero = (aluResult == '0);
    assign lzcExt  = {{(EwWidth - LzcWidth){1'b0}}, lzc};

    assign shifted = carry ? (aluResult >> 1) : (aluResult << lzc);
    assign adjExp  = carry ? (expWork + EwWidth'(1)) : (expWork - lzcExt);

    always_comb begin
        if (sigZero && !expWork[EwWidth-1]) begin
            packWord = '0; // exact cancellation
        end else if (adjExp <= 0) begin
            packWord = {resultSign, {(ExpWidth + FracWidth){1'b0}}}; // flush to signed zero
        end else if (adjExp >= MaxExp) begin
            packWord = {resultSign, {ExpWidth{1'b1}}, {FracWidth{1'b0}}};
        end else begin
            // hidden one dropped, guard bits truncated
            packWord = {resultSign, adjExp[ExpWidth-1:0], shifted[SigWidth-2 -: FracWidth]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (normLoad) begin
            result <= packWord;
        end
    end

endmodule

//--- source/fpuTop.sv
module fpuTop
    import fpuPkg::*;
#(
    parameter int ExpWidth  = 8,
    parameter int FracWidth = 23
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req,
    input  fpuOpT                       op,
    input  logic [ExpWidth+FracWidth:0] a,
    input  logic [ExpWidth+FracWidth:0] b,
    output logic                        ack,
    output logic [ExpWidth+FracWidth:0] result
);

    localparam int SigWidth = FracWidth + 1 + GuardBits;

    // operand fields
    wire                 signA = a[ExpWidth+FracWidth];
    wire                 signB = b[ExpWidth+FracWidth];
    wire [ExpWidth-1:0]  expA  = a[FracWidth +: ExpWidth];
    wire [ExpWidth-1:0]  expB  = b[FracWidth +: ExpWidth];
    wire [FracWidth-1:0] fracA = a[FracWidth-1:0];
    wire [FracWidth-1:0] fracB = b[FracWidth-1:0];

    logic                       cmpLoad;
    logic                       alignLoad;
    logic                       aluStart;
    logic                       normLoad;
    logic                       isMul;
    logic                       effSub;
    logic                       resultSign;
    logic                       aLarger;
    logic                       aluDone;
    logic [ExpWidth-1:0]        expDiff;
    logic signed [ExpWidth+1:0] expWork;
    logic [SigWidth-1:0]        bigSig;
    logic [SigWidth-1:0]        smallSig;
    logic [SigWidth:0]          aluResult; // one carry bit above the significand

    fpuControl control (
        .clk(clk), .reset(reset), .req(req), .op(op),
        .signA(signA), .signB(signB), .aLarger(aLarger), .aluDone(aluDone),
        .ack(ack), .cmpLoad(cmpLoad), .alignLoad(alignLoad), .aluStart(aluStart),
        .isMul(isMul), .effSub(effSub), .normLoad(normLoad), .resultSign(resultSign)
    );

    exponentAlu #(.ExpWidth(ExpWidth), .FracWidth(FracWidth)) expAlu (
        .clk(clk), .reset(reset), .cmpLoad(cmpLoad), .isMul(isMul),
        .expA(expA), .expB(expB), .fracA(fracA), .fracB(fracB),
        .aLarger(aLarger), .expDiff(expDiff), .expWork(expWork)
    );

    alignShifter #(.ExpWidth(ExpWidth), .FracWidth(FracWidth)) align (
        .clk(clk), .reset(reset), .alignLoad(alignLoad), .aLarger(aLarger),
        .expDiff(expDiff), .expA(expA), .expB(expB), .fracA(fracA), .fracB(fracB),
        .bigSig(bigSig), .smallSig(smallSig)
    );

    mantissaAlu #(.FracWidth(FracWidth)) bigAlu (
        .clk(clk), .reset(reset), .aluStart(aluStart), .isMul(isMul), .effSub(effSub),
        .bigSig(bigSig), .smallSig(smallSig), .aluResult(aluResult), .aluDone(aluDone)
    );

    normalizer #(.ExpWidth(ExpWidth), .FracWidth(FracWidth)) norm (
        .clk(clk), .reset(reset), .normLoad(normLoad), .aluResult(aluResult),
        .expWork(expWork), .resultSign(resultSign), .result(result)
    );

endmodule

//--- verif/fpuRefModel.svh
`ifndef FPU_REF_MODEL_SVH
`define FPU_REF_MODEL_SVH

// significand with its hidden one or zero for a zero exponent
function automatic longint significand(input logic [Width-1:0] v);
    if (v[Width-2:FracWidth] == 0) begin
        return 0;
    end
    return (longint'(1) << FracWidth) | v[FracWidth-1:0];
endfunction

// sig carries GuardBits extra low bits below the ones place at FracWidth+GuardBits
function automatic logic [Width-1:0] packValue(input logic sign, input longint expIn,
                                               input longint sig);
    longint e;
    longint s;
    e = expIn;
    s = sig;
    if (s == 0) begin
        return '0; // exact cancellation is always +0
    end
    while (s >= (longint'(1) << (FracWidth + GuardBits + 1))) begin
        s = s >> 1;
        e = e + 1;
    end
    while (s < (longint'(1) << (FracWidth + GuardBits))) begin
        s = s << 1;
        e = e - 1;
    end
    if (e <= 0) begin
        return {sign, {(Width - 1){1'b0}}};
    end
    if (e >= (1 << ExpWidth) - 1) begin
        return {sign, {ExpWidth{1'b1}}, {FracWidth{1'b0}}};
    end
    return {sign, e[ExpWidth-1:0], s[FracWidth+GuardBits-1:GuardBits]}; // truncate
endfunction

function automatic logic [Width-1:0] modelAddSub(input logic [Width-1:0] x,
                                                 input logic [Width-1:0] y,
                                                 input logic subtract);
    logic [Width-1:0] bigOp;
    logic [Width-1:0] smallOp;
    logic             signBig;
    logic             signSmall;
    longint           gap;
    longint           sigSmall;
    if (x[Width-2:0] >= y[Width-2:0]) begin
        bigOp     = x;
        smallOp   = y;
        signBig   = x[Width-1];
        signSmall = y[Width-1] ^ subtract;
    end else begin
        bigOp     = y;
        smallOp   = x;
        signBig   = y[Width-1] ^ subtract;
        signSmall = x[Width-1];
    end
    gap = bigOp[Width-2:FracWidth] - smallOp[Width-2:FracWidth];
    sigSmall = (gap > FracWidth + GuardBits) ? 0 :
               ((significand(smallOp) << GuardBits) >> gap); // no sticky bit
    if (signBig == signSmall) begin
        return packValue(signBig, bigOp[Width-2:FracWidth],
                         (significand(bigOp) << GuardBits) + sigSmall);
    end
    return packValue(signBig, bigOp[Width-2:FracWidth],
                     (significand(bigOp) << GuardBits) - sigSmall);
endfunction

function automatic logic [Width-1:0] modelMul(input logic [Width-1:0] x,
                                              input logic [Width-1:0] y);
    logic   sign;
    longint expSum;
    longint product;
    sign = x[Width-1] ^ y[Width-1];
    if (significand(x) == 0 || significand(y) == 0) begin
        return {sign, {(Width - 1){1'b0}}};
    end
    expSum  = x[Width-2:FracWidth];
    expSum  = expSum + y[Width-2:FracWidth] - ((1 << (ExpWidth - 1)) - 1);
    product = significand(x) * significand(y);
    // line the binary point up with a sum and drop the low product bits
    return packValue(sign, expSum, product >> (FracWidth - GuardBits));
endfunction

`endif

//--- verif/fpuTb.sv
module fpuTb
    import fpuPkg::*;
();

    localparam int ExpWidth  = 8;
    localparam int FracWidth = 23;
    localparam int Width     = ExpWidth + FracWidth + 1;
    localparam int Timeout   = 100; // cycles per wait on ack

    logic             clk;
    logic             reset;
    logic             req;
    fpuOpT            op;
    logic [Width-1:0] a;
    logic [Width-1:0] b;
    logic             ack;
    logic [Width-1:0] result;
    integer           seed;

    `include "fpuRefModel.svh"

    fpuTop #(.ExpWidth(ExpWidth), .FracWidth(FracWidth)) DUT (
        .clk(clk), .reset(reset), .req(req), .op(op), .a(a), .b(b),
        .ack(ack), .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [Width-1:0] expected,
                              input logic [Width-1:0] actual);
        if (actual !== expected) begin
            stopRun($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic int randBelow(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // random sign and fraction with exponent 1 to 254 or sometimes a signed zero
    function automatic logic [Width-1:0] randomOperand(input int zeroOdds);
        logic [Width-1:0] v;
        v = $random(seed);
        v[Width-2:FracWidth] = ExpWidth'(1 + randBelow((1 << ExpWidth) - 2));
        if (randBelow(100) < zeroOdds) begin
            v[Width-2:0] = '0;
        end
        return v;
    endfunction

    task automatic runOp(input fpuOpT opIn, input logic [Width-1:0] x,
                         input logic [Width-1:0] y);
        logic [Width-1:0] expected;
        logic [Width-1:0] held;
        int               cycles;
        case (opIn)
            opAdd:   expected = modelAddSub(x, y, 1'b0);
            opSub:   expected = modelAddSub(x, y, 1'b1);
            default: expected = modelMul(x, y);
        endcase
        @(posedge clk);
        op  <= opIn;
        a   <= x;
        b   <= y;
        req <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > Timeout) stopRun("ack never rose after req was raised");
        end while (!ack);
        if (opIn != opMul) begin
            checkValue("ack latency", 7, cycles); // counted from the edge driving req
        end
        checkValue("result", expected, result);
        held = result;
        repeat (randBelow(6)) begin   // requester is slow to let go
            @(posedge clk);
            checkValue("ack", 1, ack);
            checkValue("result", held, result);
        end
        req <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            checkValue("result", held, result);
            if (cycles > Timeout) stopRun("ack never fell after req was lowered");
        end while (ack);
    endtask

    initial begin
        logic [Width-1:0] x;
        logic [Width-1:0] y;
        seed  = 32'h1227;
        reset = 1'b1;
        req   = 1'b0;
        op    = opAdd;
        a     = '0;
        b     = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        repeat (5) begin
            @(posedge clk);
            checkValue("ack", '0, ack);
        end
        repeat (300) runOp(opAdd, randomOperand(5), randomOperand(5));
        repeat (200) begin
            x = randomOperand(5);
            case (randBelow(4))
                0:       y = x;
                1:       y = (x[Width-2:FracWidth] == 0) ? x : (x ^ Width'(randBelow(256)));
                default: y = randomOperand(5);
            endcase
            runOp(opSub, x, y);
        end
        for (int i = 0; i < 200; i++) begin
            x = randomOperand(5);
            y = randomOperand(5);
            if (i % 10 == 0) begin // exponent sum overflows
                x[Width-2:FracWidth] = ExpWidth'(200 + randBelow(54));
                y[Width-2:FracWidth] = ExpWidth'(200 + randBelow(54));
            end else if (i % 10 == 1) begin // exponent sum underflows
                x[Width-2:FracWidth] = ExpWidth'(1 + randBelow(40));
                y[Width-2:FracWidth] = ExpWidth'(1 + randBelow(40));
            end
            runOp(opMul, x, y);
        end
        for (int i = 0; i < 12; i++) begin
            x = randomOperand(0);
            y = {1'(randBelow(2)), {(Width - 1){1'b0}}}; // signed zero
            runOp(fpuOpT'(i % 3), x, y);
            if (i % 3 == 2) begin
                checkValue("result", {x[Width-1] ^ y[Width-1], {(Width - 1){1'b0}}}, result);
            end else begin
                checkValue("result", x, result);
            end
            runOp(fpuOpT'(i % 3), y, x);
            runOp(fpuOpT'(i % 3), y, y);
        end
        $display("Test passed");
        $finish;
    end

endmodule

//--- project.f
+incdir+verif
common/fpuPkg.sv
fpu/fpuControl.sv
fpu/exponentAlu.sv
fpu/alignShifter.sv
fpu/mantissaAlu.sv
fpu/normalizer.sv
source/fpuTop.sv
verif/fpuTb.sv
